// File: list.f
hdl/mmu_pkg.sv
hdl/tlb_lookup.sv
hdl/tlb_entry_file.sv
hdl/translate_ctrl.sv
hdl/mmu_top.sv
verif/pt_mem_model.sv
verif/mmu_tb.sv

// File: verif/mmu_tb.sv
// ##################################################
// 16 virtual pages from vpn 0 with a random page table
// pages 0 to 2 forced to cover each PTE case
// ##################################################
`timescale 1ns/1ns
module mmu_tb;

    logic             clk = 1'b0;
    logic             rst, flush, req_valid, req_write, req_is_mem, rsp_ready;
    logic [31:0]      pt_base = 32'h0000_4000;   // 64-byte aligned for the memory model
    logic [31:0]      req_addr, rsp_paddr, mem_addr, mem_rdata;
    logic             req_ready, rsp_valid, rsp_pcd;
    mmu_pkg::fault_e  rsp_fault;
    logic             mem_req_valid, mem_req_ready, mem_rsp_valid, mem_rsp_ready;
    bit               pt_p [16], pt_rw [16], pt_pcd [16];   // own copy of the page table
    logic [19:0]      pt_pfn [16];
    logic [31:0]      cur_vpn = '0;   // vpn of the request in flight
    int               errors = 0, cycle = 0, issued = 0, mem_cnt = 0;

    mmu_top dut_i (
        .clk(clk), .rst(rst), .flush(flush), .pt_base(pt_base),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
        .req_write(req_write), .req_is_mem(req_is_mem),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_paddr(rsp_paddr),
        .rsp_pcd(rsp_pcd), .rsp_fault(rsp_fault),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_addr(mem_addr),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp_ready(mem_rsp_ready), .mem_rdata(mem_rdata)
    );

    pt_mem_model mem_i (
        .clk(clk), .rst(rst), .mem_req_valid(mem_req_valid), .mem_addr(mem_addr),
        .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_ready(mem_rsp_ready), .mem_rdata(mem_rdata)
    );

    always #5 clk = ~clk;

    // cycle count, walk count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (mem_req_valid && mem_req_ready) mem_cnt <= mem_cnt + 1;
        if (cycle > 100 * issued + 200) begin
            $display("timeout after %0d cycles with %0d requests issued", cycle, issued);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (rst) rsp_valid && !rsp_ready |=>
        rsp_valid && $stable(rsp_paddr) && $stable(rsp_pcd) && $stable(rsp_fault))
        else begin
            $display("response changed at %0t before it was taken", $time);
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst) rsp_valid |-> !req_ready)
        else begin
            $display("req_ready high at %0t while a response is pending", $time);
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst) mem_req_valid && !mem_req_ready |=>
        mem_req_valid && $stable(mem_addr))
        else begin
            $display("memory request dropped or changed at %0t under a stall", $time);
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> mem_addr == pt_base + (cur_vpn << 2))
        else begin
            $display("mismatch at %0t: mem_addr = %h, expected %h", $time, mem_addr,
                     pt_base + (cur_vpn << 2));
            errors++;
        end
    // the pte word only comes back during a walk
    assert property (@(posedge clk) disable iff (rst) mem_rsp_valid |-> mem_rsp_ready)
        else begin
            $display("memory response offered at %0t while mem_rsp_ready is low", $time);
            errors++;
        end

    task automatic report_mismatch(input string name, input logic [31:0] got, exp);
        $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    // expected response from the table (paddr and pcd count only without a fault)
    function automatic void predict(input logic [31:0] addr, input bit wr, input bit mem,
                                    output logic [31:0] paddr, output bit pcd,
                                    output logic [1:0] fault);
        int p;
        p     = addr[15:12];
        paddr = addr;
        pcd   = 1'b0;
        fault = mmu_pkg::FAULT_NONE;
        if (mem && !pt_p[p]) fault = mmu_pkg::FAULT_PAGE;
        else if (mem && wr && !pt_rw[p]) fault = mmu_pkg::FAULT_PROT;
        else if (mem) begin
            paddr = {pt_pfn[p], addr[11:0]};
            pcd   = pt_pcd[p];
        end
    endfunction

    function automatic logic [31:0] make_addr(input int vpn);
        return (vpn << 12) | ($urandom & 32'hfff);   // random page offset
    endfunction

    // one request and its checks (exp_walks and exp_lat skipped when negative)
    task automatic access(input logic [31:0] addr, input bit wr, input bit mem, input bit stall,
                          input int exp_walks, input int exp_lat);
        logic [31:0] e_paddr;
        bit          e_pcd;
        logic [1:0]  e_fault;
        int          t_acc, lat, walks0;
        predict(addr, wr, mem, e_paddr, e_pcd, e_fault);
        cur_vpn    = addr >> 12;
        req_addr   = addr;
        req_write  = wr;
        req_is_mem = mem;
        req_valid  = 1'b1;
        issued++;
        walks0 = mem_cnt;
        while (!req_ready) @(negedge clk);
        @(negedge clk);                      // accepted on the edge just passed
        req_valid = 1'b0;
        t_acc     = cycle;
        lat       = -1;
        rsp_ready = !stall || ($urandom_range(0, 2) == 0);
        while (!rsp_valid || !rsp_ready) begin
            if (rsp_valid && lat < 0) lat = cycle + 1 - t_acc;   // first edge it is seen
            @(negedge clk);
            rsp_ready = !stall || ($urandom_range(0, 2) == 0);
        end
        if (lat < 0) lat = cycle + 1 - t_acc;
        assert (rsp_fault == e_fault) else report_mismatch("rsp_fault", rsp_fault, e_fault);
        if (e_fault == mmu_pkg::FAULT_NONE) begin
            assert (rsp_paddr == e_paddr)
            else report_mismatch("rsp_paddr", rsp_paddr, e_paddr);
            assert (rsp_pcd == e_pcd) else report_mismatch("rsp_pcd", rsp_pcd, e_pcd);
        end
        if (exp_walks >= 0) begin
            assert (mem_cnt - walks0 == exp_walks)
            else report_mismatch("memory requests", mem_cnt - walks0, exp_walks);
        end
        if (exp_lat >= 0) begin
            assert (lat == exp_lat) else report_mismatch("latency", lat, exp_lat);
        end
        @(negedge clk);                      // controller back in idle after the response
    endtask

    task automatic show_result(input string name, input int errors_before);
        if (errors == errors_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    initial begin
        int e0;
        int order [16];
        int j;
        int tmp;
        void'($urandom(32'h4043_ecf2));
        rst        = 1'b1;
        flush      = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_write  = 1'b0;
        req_is_mem = 1'b0;
        rsp_ready  = 1'b0;
        for (int i = 0; i < 16; i++) begin
            pt_p[i]   = $urandom_range(0, 1);
            pt_rw[i]  = $urandom_range(0, 1);
            pt_pcd[i] = $urandom_range(0, 1);
            pt_pfn[i] = $urandom;
        end
        pt_p[0]  = 1'b1;   // present
        pt_p[1]  = 1'b1;   // present and read only
        pt_rw[1] = 1'b0;
        pt_p[2]  = 1'b0;   // not present
        for (int i = 0; i < 16; i++)
            mem_i.pte[i] = (pt_pfn[i] << mmu_pkg::PTE_PFN_LSB)
                         | (pt_pcd[i] << mmu_pkg::PTE_PCD_BIT)
                         | (pt_rw[i] << mmu_pkg::PTE_RW_BIT) | (pt_p[i] << mmu_pkg::PTE_P_BIT);
        repeat (2) @(negedge clk);
        rst = 1'b0;
        assert (req_ready && !rsp_valid && !mem_req_valid && dut_i.entry_valid == '0)
        else begin
            $display("DUT not idle with an empty TLB after reset");
            errors++;
        end

        e0 = errors;
        access(make_addr(0), 1'b0, 1'b1, 1'b0, 1, -1);
        access(make_addr(0), 1'b0, 1'b1, 1'b0, 0, 2);   // hits with no walk
        show_result("read_hit", e0);
        e0 = errors;
        access(make_addr(1), 1'b1, 1'b1, 1'b0, -1, -1);
        access(make_addr(1), 1'b0, 1'b1, 1'b0, 0, 2);
        show_result("write_protect", e0);
        e0 = errors;
        access(make_addr(2), 1'b0, 1'b1, 1'b0, 1, -1);
        access(make_addr(2), 1'b0, 1'b1, 1'b0, 1, -1);  // walks again since nothing was filled
        show_result("page_fault", e0);
        e0 = errors;
        access($urandom, 1'b1, 1'b0, 1'b0, 0, 2);
        show_result("non_memory", e0);

        e0 = errors;
        for (int i = 0; i < 16; i++) order[i] = i;
        for (int i = 15; i > 0; i--) begin
            j        = $urandom_range(0, i);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 16; i++) begin
            access(make_addr(order[i]), $urandom_range(0, 1), 1'b1, 1'b0, -1, -1);
        end
        access(make_addr(0), 1'b0, 1'b1, 1'b0, -1, -1);
        flush = 1'b1;                        // controller idle here
        @(negedge clk);
        flush = 1'b0;
        access(make_addr(0), 1'b0, 1'b1, 1'b0, 1, -1);
        show_result("sweep_flush", e0);

        e0 = errors;
        repeat (24) access(make_addr($urandom_range(0, 15)), $urandom_range(0, 1),
                           $urandom_range(0, 3) != 0, 1'b1, -1, -1);
        show_result("back_pressure", e0);

        $display("%0d requests, %0d errors", issued, errors);
        if (errors == 0) $display("TESTBENCH PASSED");
        else $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: verif/pt_mem_model.sv
// ##################################################
// 16 PTE words indexed by mem_addr[5:2], pt_base 64-byte aligned
// one read outstanding, contents written by the testbench
// ##################################################
`timescale 1ns/1ns
module pt_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req_valid,
    input  logic [31:0] mem_addr,
    output logic        mem_req_ready,
    output logic        mem_rsp_valid,
    input  logic        mem_rsp_ready,
    output logic [31:0] mem_rdata
);

    logic [31:0] pte [16];        // page table words
    logic        req_seen_q;      // request taken on the last rising edge
    logic        rsp_seen_q;      // response taken on the last rising edge
    logic [31:0] addr_q;
    int          wait_cnt = -1;   // falling edges left before the response, -1 when idle

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rdata     = '0;
    end

    always @(posedge clk) begin
        req_seen_q <= mem_req_valid && mem_req_ready;
        rsp_seen_q <= mem_rsp_valid && mem_rsp_ready;
        if (mem_req_valid && mem_req_ready) addr_q <= mem_addr;
    end

    // outputs move on the falling edge, response 1 to 4 cycles after the request
    always @(negedge clk) begin
        mem_req_ready <= !rst && ($urandom_range(0, 2) != 0);   // stalls about 1 cycle in 3
        if (rst) begin
            mem_rsp_valid <= 1'b0;
            wait_cnt = -1;
        end else begin
            if (rsp_seen_q) mem_rsp_valid <= 1'b0;
            if (req_seen_q) wait_cnt = $urandom_range(0, 3);
            if (wait_cnt == 0) begin
                mem_rsp_valid <= 1'b1;
                mem_rdata     <= pte[addr_q[5:2]];
            end
            if (wait_cnt >= 0) wait_cnt = wait_cnt - 1;
        end
    end

endmodule

// File: hdl/mmu_top.sv
// ##################################################
// drive flush only while req_ready is high
// ##################################################
`timescale 1ns/1ns
module mmu_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic [mmu_pkg::ADDR_W-1:0] pt_base,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic [mmu_pkg::ADDR_W-1:0] req_addr,
    input  logic                       req_write,
    input  logic                       req_is_mem,
    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output logic [mmu_pkg::ADDR_W-1:0] rsp_paddr,
    output logic                       rsp_pcd,
    output mmu_pkg::fault_e            rsp_fault,
    output logic                       mem_req_valid,
    input  logic                       mem_req_ready,
    output logic [mmu_pkg::ADDR_W-1:0] mem_addr,
    input  logic                       mem_rsp_valid,
    output logic                       mem_rsp_ready,
    input  logic [mmu_pkg::ADDR_W-1:0] mem_rdata
);

    logic [mmu_pkg::TLB_ENTRIES*mmu_pkg::VPN_W-1:0] entry_vpn;   // flat entry vectors
    logic [mmu_pkg::TLB_ENTRIES*mmu_pkg::PFN_W-1:0] entry_pfn;
    logic [mmu_pkg::TLB_ENTRIES-1:0]                entry_valid;
    logic [mmu_pkg::TLB_ENTRIES-1:0]                entry_rw;
    logic [mmu_pkg::TLB_ENTRIES-1:0]                entry_pcd;
    logic [mmu_pkg::ADDR_W-1:0]                     va;          // held request to lookup
    logic                                           write;
    logic                                           is_mem;
    logic                                           hit;
    logic [mmu_pkg::PFN_W-1:0]                      pfn;
    logic                                           pcd;
    mmu_pkg::fault_e                                fault;
    logic                                           fill_en;
    logic [mmu_pkg::VPN_W-1:0]                      fill_vpn;
    logic [mmu_pkg::PFN_W-1:0]                      fill_pfn;
    logic                                           fill_rw;
    logic                                           fill_pcd;

    tlb_entry_file entry_file_i (
        .clk(clk), .rst(rst), .flush(flush),
        .fill_en(fill_en), .fill_vpn(fill_vpn), .fill_pfn(fill_pfn),
        .fill_rw(fill_rw), .fill_pcd(fill_pcd),
        .entry_vpn(entry_vpn), .entry_pfn(entry_pfn), .entry_valid(entry_valid),
        .entry_rw(entry_rw), .entry_pcd(entry_pcd)
    );

    tlb_lookup lookup_i (
        .va(va), .write(write), .is_mem(is_mem),
        .entry_vpn(entry_vpn), .entry_pfn(entry_pfn), .entry_valid(entry_valid),
        .entry_rw(entry_rw), .entry_pcd(entry_pcd),
        .hit(hit), .pfn(pfn), .pcd(pcd), .fault(fault)
    );

    translate_ctrl ctrl_i (
        .clk(clk), .rst(rst), .pt_base(pt_base),
        .req_valid(req_valid), .req_addr(req_addr), .req_write(req_write),
        .req_is_mem(req_is_mem), .rsp_ready(rsp_ready),
        .hit(hit), .pfn(pfn), .pcd(pcd), .fault(fault),
        .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata),
        .req_ready(req_ready), .va(va), .write(write), .is_mem(is_mem),
        .rsp_valid(rsp_valid), .rsp_paddr(rsp_paddr), .rsp_pcd(rsp_pcd),
        .rsp_fault(rsp_fault), .mem_req_valid(mem_req_valid), .mem_addr(mem_addr),
        .mem_rsp_ready(mem_rsp_ready), .fill_en(fill_en), .fill_vpn(fill_vpn),
        .fill_pfn(fill_pfn), .fill_rw(fill_rw), .fill_pcd(fill_pcd)
    );

endmodule

// File: hdl/translate_ctrl.sv
// ##################################################
// one request in flight, req_ready only in S_IDLE
// pt_base must stay stable while a walk is in progress
// ##################################################
`timescale 1ns/1ns
module translate_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [mmu_pkg::ADDR_W-1:0]    pt_base,        // page table base address
    input  logic                          req_valid,
    input  logic [mmu_pkg::ADDR_W-1:0]    req_addr,
    input  logic                          req_write,
    input  logic                          req_is_mem,
    input  logic                          rsp_ready,
    input  logic                          hit,
    input  logic [mmu_pkg::PFN_W-1:0]     pfn,
    input  logic                          pcd,
    input  mmu_pkg::fault_e               fault,
    input  logic                          mem_req_ready,
    input  logic                          mem_rsp_valid,
    input  logic [mmu_pkg::ADDR_W-1:0]    mem_rdata,      // pte word
    output logic                          req_ready,
    output logic [mmu_pkg::ADDR_W-1:0]    va,
    output logic                          write,
    output logic                          is_mem,
    output logic                          rsp_valid,
    output logic [mmu_pkg::ADDR_W-1:0]    rsp_paddr,
    output logic                          rsp_pcd,
    output mmu_pkg::fault_e               rsp_fault,
    output logic                          mem_req_valid,
    output logic [mmu_pkg::ADDR_W-1:0]    mem_addr,
    output logic                          mem_rsp_ready,
    output logic                          fill_en,
    output logic [mmu_pkg::VPN_W-1:0]     fill_vpn,
    output logic [mmu_pkg::PFN_W-1:0]     fill_pfn,
    output logic                          fill_rw,
    output logic                          fill_pcd
);

    mmu_pkg::ctrl_state_e              state_q;
    mmu_pkg::ctrl_state_e              state_d;
    logic [mmu_pkg::ADDR_W-1:0]        va_q;          // held request
    logic                              write_q;
    logic                              is_mem_q;
    logic [mmu_pkg::ADDR_W-1:0]        mem_addr_q;    // pte address, stable under stall
    logic [mmu_pkg::PFN_W-1:0]         pte_pfn_q;     // decoded pte for the fill
    logic                              pte_rw_q;
    logic                              pte_pcd_q;
    logic [mmu_pkg::ADDR_W-1:0]        rsp_paddr_q;
    logic                              rsp_pcd_q;
    mmu_pkg::fault_e                   rsp_fault_q;
    logic [mmu_pkg::VPN_W-1:0]         vpn;
    logic [mmu_pkg::ADDR_W-1:0]        pte_addr;
    logic                              accept;
    logic                              pte_present;

    assign accept      = req_valid && req_ready;
    assign vpn         = va_q[mmu_pkg::ADDR_W-1 -: mmu_pkg::VPN_W];
    // pt_base + 4 * vpn
    assign pte_addr    = pt_base + {{(mmu_pkg::ADDR_W-mmu_pkg::VPN_W-2){1'b0}}, vpn, 2'b00};
    assign pte_present = mem_rdata[mmu_pkg::PTE_P_BIT];

    always_comb begin
        state_d = state_q;
        case (state_q)
            mmu_pkg::S_IDLE:      if (req_valid) state_d = mmu_pkg::S_LOOKUP;
            mmu_pkg::S_LOOKUP:    state_d = hit ? mmu_pkg::S_RESP : mmu_pkg::S_WALK_REQ;
            mmu_pkg::S_WALK_REQ:  if (mem_req_ready) state_d = mmu_pkg::S_WALK_WAIT;
            mmu_pkg::S_WALK_WAIT: begin
                if (mem_rsp_valid) begin
                    state_d = pte_present ? mmu_pkg::S_FILL : mmu_pkg::S_RESP;
                end
            end
            mmu_pkg::S_FILL:      state_d = mmu_pkg::S_LOOKUP;   // lookup again, now hits
            mmu_pkg::S_RESP:      if (rsp_ready) state_d = mmu_pkg::S_IDLE;
            default:              state_d = mmu_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state_q <= mmu_pkg::S_IDLE;
        else     state_q <= state_d;
    end

    // request, walk and response registers
    always_ff @(posedge clk) begin
        if (accept) begin
            va_q     <= req_addr;
            write_q  <= req_write;
            is_mem_q <= req_is_mem;
        end
        if (state_q == mmu_pkg::S_LOOKUP && !hit) mem_addr_q <= pte_addr;
        if (state_q == mmu_pkg::S_WALK_WAIT && mem_rsp_valid) begin
            pte_pfn_q <= mem_rdata[mmu_pkg::PTE_PFN_LSB +: mmu_pkg::PFN_W];
            pte_rw_q  <= mem_rdata[mmu_pkg::PTE_RW_BIT];
            pte_pcd_q <= mem_rdata[mmu_pkg::PTE_PCD_BIT];
        end
        if (state_q == mmu_pkg::S_LOOKUP && hit) begin
            // non-memory requests pass straight through
            rsp_paddr_q <= is_mem_q ? {pfn, va_q[mmu_pkg::PAGE_OFFSET_W-1:0]} : va_q;
            rsp_pcd_q   <= is_mem_q && pcd;
            rsp_fault_q <= fault;
        end else if (state_q == mmu_pkg::S_WALK_WAIT && mem_rsp_valid && !pte_present) begin
            rsp_paddr_q <= va_q;                  // no frame on a page fault
            rsp_pcd_q   <= 1'b0;
            rsp_fault_q <= mmu_pkg::FAULT_PAGE;
        end
    end

    assign req_ready     = (state_q == mmu_pkg::S_IDLE);
    assign va            = va_q;
    assign write         = write_q;
    assign is_mem        = is_mem_q;
    assign rsp_valid     = (state_q == mmu_pkg::S_RESP);
    assign rsp_paddr     = rsp_paddr_q;
    assign rsp_pcd       = rsp_pcd_q;
    assign rsp_fault     = rsp_fault_q;
    assign mem_req_valid = (state_q == mmu_pkg::S_WALK_REQ);
    assign mem_addr      = mem_addr_q;
    assign mem_rsp_ready = (state_q == mmu_pkg::S_WALK_WAIT);
    assign fill_en       = (state_q == mmu_pkg::S_FILL);
    assign fill_vpn      = vpn;
    assign fill_pfn      = pte_pfn_q;
    assign fill_rw       = pte_rw_q;
    assign fill_pcd      = pte_pcd_q;

endmodule

// File: hdl/tlb_entry_file.sv
// ##################################################
// flush wins over a fill in the same cycle
// replacement is plain round robin, invalid slots are not preferred
// ##################################################
`timescale 1ns/1ns
module tlb_entry_file (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           flush,      // clear all valid bits
    input  logic                                           fill_en,
    input  logic [mmu_pkg::VPN_W-1:0]                      fill_vpn,
    input  logic [mmu_pkg::PFN_W-1:0]                      fill_pfn,
    input  logic                                           fill_rw,
    input  logic                                           fill_pcd,
    output logic [mmu_pkg::TLB_ENTRIES*mmu_pkg::VPN_W-1:0] entry_vpn,
    output logic [mmu_pkg::TLB_ENTRIES*mmu_pkg::PFN_W-1:0] entry_pfn,
    output logic [mmu_pkg::TLB_ENTRIES-1:0]                entry_valid,
    output logic [mmu_pkg::TLB_ENTRIES-1:0]                entry_rw,
    output logic [mmu_pkg::TLB_ENTRIES-1:0]                entry_pcd
);

    logic [mmu_pkg::VPN_W-1:0]       vpn_q [mmu_pkg::TLB_ENTRIES];   // tags
    logic [mmu_pkg::PFN_W-1:0]       pfn_q [mmu_pkg::TLB_ENTRIES];   // frames
    logic [mmu_pkg::TLB_ENTRIES-1:0] valid_q;
    logic [mmu_pkg::TLB_ENTRIES-1:0] rw_q;
    logic [mmu_pkg::TLB_ENTRIES-1:0] pcd_q;
    logic [mmu_pkg::TLB_IDX_W-1:0]   victim_q;                        // next slot to replace
    logic                            do_fill;

    assign do_fill = fill_en && !flush;

    // control state: valid bits and victim pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (flush) begin
            valid_q <= '0;                     // pointer keeps its position
        end else if (fill_en) begin
            valid_q[victim_q] <= 1'b1;
            victim_q          <= victim_q + 1'b1;   // wraps at TLB_ENTRIES
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (do_fill) begin
            vpn_q[victim_q] <= fill_vpn;
            pfn_q[victim_q] <= fill_pfn;
            rw_q[victim_q]  <= fill_rw;
            pcd_q[victim_q] <= fill_pcd;
        end
    end

    // flatten for the lookup
    genvar i;
    generate
        for (i = 0; i < mmu_pkg::TLB_ENTRIES; i = i + 1) begin : g_flat
            assign entry_vpn[i*mmu_pkg::VPN_W +: mmu_pkg::VPN_W] = vpn_q[i];
            assign entry_pfn[i*mmu_pkg::PFN_W +: mmu_pkg::PFN_W] = pfn_q[i];
        end
    endgenerate

    assign entry_valid = valid_q;
    assign entry_rw    = rw_q;
    assign entry_pcd   = pcd_q;

endmodule

// File: hdl/tlb_lookup.sv
// ##################################################
// purely combinational, assumes at most one valid tag matches
// ##################################################
`timescale 1ns/1ns
module tlb_lookup (
    input  logic [mmu_pkg::ADDR_W-1:0]                  va,          // address to translate
    input  logic                                        write,
    input  logic                                        is_mem,      // low means no translation
    input  logic [mmu_pkg::TLB_ENTRIES*mmu_pkg::VPN_W-1:0] entry_vpn,
    input  logic [mmu_pkg::TLB_ENTRIES*mmu_pkg::PFN_W-1:0] entry_pfn,
    input  logic [mmu_pkg::TLB_ENTRIES-1:0]             entry_valid,
    input  logic [mmu_pkg::TLB_ENTRIES-1:0]             entry_rw,
    input  logic [mmu_pkg::TLB_ENTRIES-1:0]             entry_pcd,
    output logic                                        hit,
    output logic [mmu_pkg::PFN_W-1:0]                   pfn,
    output logic                                        pcd,
    output mmu_pkg::fault_e                             fault
);

    logic [mmu_pkg::VPN_W-1:0]       vpn;
    logic [mmu_pkg::TLB_ENTRIES-1:0] match;     // one-hot on a hit
    logic                            tag_hit;
    logic                            rw_sel;    // write permission of the matching entry

    assign vpn = va[mmu_pkg::ADDR_W-1 -: mmu_pkg::VPN_W];

    // tag compare per entry, only valid entries can match
    genvar i;
    generate
        for (i = 0; i < mmu_pkg::TLB_ENTRIES; i = i + 1) begin : g_cmp
            assign match[i] = entry_valid[i] &&
                              (entry_vpn[i*mmu_pkg::VPN_W +: mmu_pkg::VPN_W] == vpn);
        end
    endgenerate

    assign tag_hit = |match;

    // and-or mux, all zero when nothing matches
    always_comb begin
        pfn    = '0;
        pcd    = 1'b0;
        rw_sel = 1'b0;
        for (int k = 0; k < mmu_pkg::TLB_ENTRIES; k++) begin
            pfn    = pfn | (entry_pfn[k*mmu_pkg::PFN_W +: mmu_pkg::PFN_W] & {mmu_pkg::PFN_W{match[k]}});
            pcd    = pcd | (entry_pcd[k] & match[k]);
            rw_sel = rw_sel | (entry_rw[k] & match[k]);
        end
    end

    // non-memory requests always count as a hit
    assign hit = tag_hit || !is_mem;

    always_comb begin
        fault = mmu_pkg::FAULT_NONE;
        if (is_mem && tag_hit && write && !rw_sel) begin
            fault = mmu_pkg::FAULT_PROT;   // write to read-only page
        end
    end

endmodule

// File: hdl/mmu_pkg.sv
// ##################################################
// TLB_ENTRIES must be a power of two (the victim pointer wraps)
// 4 KB pages and a single-level page table only
// ##################################################
package mmu_pkg;

    localparam int ADDR_W        = 32;                    // virtual and physical address width
    localparam int TLB_ENTRIES   = 8;
    localparam int TLB_IDX_W     = $clog2(TLB_ENTRIES);   // victim pointer width
    localparam int VPN_W         = 20;                    // virtual page number
    localparam int PFN_W         = 20;                    // page frame number
    localparam int PAGE_OFFSET_W = 12;                    // 4 KB pages

    // PTE layout, one 32-bit word per virtual page
    localparam int PTE_P_BIT     = 0;   // present
    localparam int PTE_RW_BIT    = 1;   // writable, 0 means read only
    localparam int PTE_PCD_BIT   = 4;   // cache disable, set for mmio pages
    localparam int PTE_PFN_LSB   = 12;  // frame number occupies 31:12

    // fault code returned with every response
    typedef enum logic [1:0] {
        FAULT_NONE = 2'd0,
        FAULT_PAGE = 2'd1,   // pte not present
        FAULT_PROT = 2'd2    // write to a read-only page
    } fault_e;

    // translation controller states
    typedef enum logic [2:0] {
        S_IDLE      = 3'd0,  // waiting for a request
        S_LOOKUP    = 3'd1,  // tlb compare on the held request
        S_WALK_REQ  = 3'd2,  // pte read issued to memory
        S_WALK_WAIT = 3'd3,  // waiting for the pte word
        S_FILL      = 3'd4,  // write the decoded pte into the tlb
        S_RESP      = 3'd5   // response held until taken
    } ctrl_state_e;

endpackage
